//--- all.f
+incdir+sim
common/mul_pkg.sv
booth/booth_encoder.sv
booth/booth_array.sv
wallace/wallace_tree.sv
hdl/operand_prep.sv
hdl/final_adder.sv
hdl/mul_top.sv
sim/tb_mul.sv

//--- booth/booth_array.sv
`timescale 1ns/1ps

module booth_array (
	input  mul_pkg::wide_ops_t         ops,
	output logic [mul_pkg::PROD_W-1:0] pp_rows [mul_pkg::PP_NUM],
	output logic [mul_pkg::PROD_W-1:0] neg_row
);

	// multiplier with the implicit zero below bit 0.
	logic [mul_pkg::OPW:0]      b_ext;
	logic [mul_pkg::OPW:0]      enc_row [mul_pkg::PP_NUM];
	logic [mul_pkg::PP_NUM-1:0] neg_bits;

	assign b_ext = {ops.b, 1'b0};

	// ********************************************************************
	// partial products
	// ********************************************************************

	for (genvar k = 0; k < mul_pkg::PP_NUM; k++) begin : g_pp
		booth_encoder u_enc (
			.window (b_ext[2*k+2 -: 3]),
			.mcand  (ops.a),
			.row    (enc_row[k]),
			.neg    (neg_bits[k])
		);

		// sign extend to the tree width, then weight by 4^k.
		assign pp_rows[k] = {{(mul_pkg::PROD_W - mul_pkg::OPW - 1){enc_row[k][mul_pkg::OPW]}},
			enc_row[k]} << (2 * k);
	end

	// ********************************************************************
	// negate correction
	// ********************************************************************

	always_comb begin
		neg_row = '0;
		for (int k = 0; k < mul_pkg::PP_NUM; k++) begin
			neg_row[2*k] = neg_bits[k];
		end
	end

endmodule

//--- booth/booth_encoder.sv
`timescale 1ns/1ps

module booth_encoder (
	input  logic [2:0]              window,
	input  logic [mul_pkg::OPW-1:0] mcand,
	output logic [mul_pkg::OPW:0]   row,
	output logic                    neg
);

	// magnitude of the selected digit.
	typedef enum logic [1:0] {
		SEL_ZERO,
		SEL_ONE,
		SEL_TWO
	} booth_sel_e;

	booth_sel_e            sel;
	logic [mul_pkg::OPW:0] mag;

	// ********************************************************************
	// radix-4 digit decode
	// ********************************************************************

	always_comb begin
		case (window)
			3'b001, 3'b010, 3'b101, 3'b110: sel = SEL_ONE;
			3'b011, 3'b100:                 sel = SEL_TWO;
			default:                        sel = SEL_ZERO;
		endcase
	end

	// 100, 101, 110 are negative; 111 is zero.
	assign neg = window[2] & ~(window[1] & window[0]);

	always_comb begin
		case (sel)
			SEL_ONE: mag = {mcand[mul_pkg::OPW-1], mcand};
			SEL_TWO: mag = {mcand, 1'b0};
			default: mag = '0;
		endcase
	end

	// one's complement here, the +1 rides in the correction row.
	assign row = neg ? ~mag : mag;

endmodule

//--- common/mul_pkg.sv
package mul_pkg;

	// ********************************************************************
	// widths
	// ********************************************************************

	// operand and result word.
	localparam int XLEN = 64;

	// operand after sign extension by two bits.
	localparam int OPW = XLEN + 2;

	// partial product rows and tree.
	localparam int PROD_W = 2 * OPW;

	// one radix-4 digit per two multiplier bits.
	localparam int PP_NUM = OPW / 2;

	// booth rows plus the negate correction row.
	localparam int TREE_ROWS = PP_NUM + 1;

	// ********************************************************************
	// types
	// ********************************************************************

	// bit 0 is the multiplicand, bit 1 the multiplier.
	typedef enum logic [1:0] {
		SIGN_UU = 2'b00,
		SIGN_SU = 2'b01,
		SIGN_US = 2'b10,
		SIGN_SS = 2'b11
	} mul_sign_e;

	typedef struct packed {
		logic [XLEN-1:0] multiplicand;
		logic [XLEN-1:0] multiplier;
		logic            mulw;
		mul_sign_e       sign;
	} mul_req_t;

	// a is the multiplicand, b the multiplier.
	typedef struct packed {
		logic [OPW-1:0] a;
		logic [OPW-1:0] b;
	} wide_ops_t;

	// redundant form of the product as sum plus carry.
	typedef struct packed {
		logic [PROD_W-1:0] sum;
		logic [PROD_W-1:0] carry;
	} csa_pair_t;

endpackage

//--- hdl/final_adder.sv
`timescale 1ns/1ps

module final_adder (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     flush,
	input  mul_pkg::csa_pair_t       csa,
	input  logic                     in_valid,
	output logic [mul_pkg::XLEN-1:0] result_hi,
	output logic [mul_pkg::XLEN-1:0] result_lo,
	output logic                     out_valid
);

	// top four bits are sign extension only.
	logic [mul_pkg::PROD_W-1:0] prod;

	// carry-propagate add of the redundant pair.
	assign prod = csa.sum + csa.carry;

	// stage 3 result registers.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			result_hi <= '0;
			result_lo <= '0;
		end else begin
			out_valid <= in_valid & ~flush;
			if (in_valid) begin
				result_hi <= prod[2*mul_pkg::XLEN-1:mul_pkg::XLEN];
				result_lo <= prod[mul_pkg::XLEN-1:0];
			end
		end
	end

endmodule

//--- hdl/mul_top.sv
`timescale 1ns/1ps

module mul_top (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     mul_valid,
	input  logic                     flush,
	input  mul_pkg::mul_req_t        req,
	output logic [mul_pkg::XLEN-1:0] result_hi,
	output logic [mul_pkg::XLEN-1:0] result_lo,
	output logic                     out_valid
);

	mul_pkg::wide_ops_t         ops;
	logic                       ops_valid;
	logic [mul_pkg::PROD_W-1:0] pp_rows [mul_pkg::PP_NUM];
	logic [mul_pkg::PROD_W-1:0] neg_row;
	mul_pkg::csa_pair_t         csa;
	logic                       csa_valid;

	// ********************************************************************
	// stage 1 widens and registers the operands
	// ********************************************************************

	operand_prep u_prep (
		.clk       (clk),
		.arst_n    (arst_n),
		.mul_valid (mul_valid),
		.flush     (flush),
		.req       (req),
		.ops       (ops),
		.ops_valid (ops_valid)
	);

	// combinational booth recode.
	booth_array u_booth (
		.ops     (ops),
		.pp_rows (pp_rows),
		.neg_row (neg_row)
	);

	// ********************************************************************
	// stages 2 and 3 reduce and then resolve
	// ********************************************************************

	wallace_tree u_tree (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.pp_rows   (pp_rows),
		.neg_row   (neg_row),
		.in_valid  (ops_valid),
		.csa       (csa),
		.csa_valid (csa_valid)
	);

	final_adder u_final (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.csa       (csa),
		.in_valid  (csa_valid),
		.result_hi (result_hi),
		.result_lo (result_lo),
		.out_valid (out_valid)
	);

endmodule

//--- hdl/operand_prep.sv
`timescale 1ns/1ps

module operand_prep (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              mul_valid,
	input  logic              flush,
	input  mul_pkg::mul_req_t req,
	output mul_pkg::wide_ops_t ops,
	output logic              ops_valid
);

	logic               accept;
	mul_pkg::wide_ops_t next_ops;

	// word ops take bit 31 as sign, then two extension bits.
	function automatic logic [mul_pkg::OPW-1:0] widen(
		input logic [mul_pkg::XLEN-1:0] x,
		input logic                     word,
		input logic                     is_signed
	);
		logic [mul_pkg::XLEN-1:0] v;
		v = word ? {{(mul_pkg::XLEN/2){x[mul_pkg::XLEN/2-1]}}, x[mul_pkg::XLEN/2-1:0]} : x;
		return {{2{is_signed & v[mul_pkg::XLEN-1]}}, v};
	endfunction

	assign accept = mul_valid & ~flush;

	assign next_ops.a = widen(req.multiplicand, req.mulw,
		req.sign inside {mul_pkg::SIGN_SU, mul_pkg::SIGN_SS});
	assign next_ops.b = widen(req.multiplier, req.mulw,
		req.sign inside {mul_pkg::SIGN_US, mul_pkg::SIGN_SS});

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ops_valid <= 1'b0;
		end else begin
			ops_valid <= accept;
		end
	end

	// stage 1 operands.
	always_ff @(posedge clk) begin
		if (accept) begin
			ops <= next_ops;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_mul --Mdir obj_dir -o tb_mul_sim \
	-f all.f

./obj_dir/tb_mul_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

//--- sim/tb_mul_tasks.svh
`ifndef TB_MUL_TASKS_SVH
`define TB_MUL_TASKS_SVH

// ********************************************************************
// reference model and stimulus
// ********************************************************************

// word ops sign extend bit 31 whatever the signedness.
function automatic logic [2*mul_pkg::XLEN-1:0] reference_product(
	input mul_pkg::mul_req_t r
);
	logic [mul_pkg::XLEN-1:0] x;
	logic [mul_pkg::XLEN-1:0] y;
	logic [1:0]               s;
	logic signed [131:0]      sx;
	logic signed [131:0]      sy;
	logic signed [131:0]      p;
	x = r.multiplicand;
	y = r.multiplier;
	s = r.sign;
	if (r.mulw) begin
		x = {{32{x[31]}}, x[31:0]};
		y = {{32{y[31]}}, y[31:0]};
	end
	sx = s[0] ? {{68{x[63]}}, x} : {68'd0, x};
	sy = s[1] ? {{68{y[63]}}, y} : {68'd0, y};
	p  = sx * sy;
	return p[127:0];
endfunction

function automatic logic [63:0] corner_value(input int i);
	case (i)
		0:       return 64'd0;
		1:       return 64'd1;
		2:       return 64'hffff_ffff_ffff_ffff;
		3:       return 64'h8000_0000_0000_0000;
		default: return 64'h7fff_ffff_ffff_ffff;
	endcase
endfunction

function automatic logic [63:0] random_word();
	return {$urandom, $urandom};
endfunction

function automatic mul_pkg::mul_req_t make_request(
	input logic [63:0] a,
	input logic [63:0] b,
	input logic        w,
	input logic [1:0]  s
);
	mul_pkg::mul_req_t r;
	r.multiplicand = a;
	r.multiplier   = b;
	r.mulw         = w;
	r.sign         = mul_pkg::mul_sign_e'(s);
	return r;
endfunction

task automatic send_request(input mul_pkg::mul_req_t r);
	@(posedge clk);
	mul_valid <= 1'b1;
	flush     <= 1'b0;
	req       <= r;
endtask

task automatic send_flush(input mul_pkg::mul_req_t r);
	@(posedge clk);
	mul_valid <= 1'b1;
	flush     <= 1'b1;
	req       <= r;
endtask

task automatic stop_driving();
	@(posedge clk);
	mul_valid <= 1'b0;
	flush     <= 1'b0;
endtask

// waits until the scoreboard drains or the drain limit runs out.
task automatic wait_for_results();
	int waited;
	waited = 0;
	do begin
		@(negedge clk);
		waited++;
	end while (exp_hi.size() != 0 && waited < DRAIN_LIMIT);
	assert (exp_hi.size() == 0) else begin
		$display("results missing at %0t: %0d requests got no result after %0d cycles",
			$time, exp_hi.size(), waited);
		errors++;
	end
endtask

task automatic finish_test(input string name, input int err_start);
	$display("%s test done: %0d errors", name, errors - err_start);
endtask

// ********************************************************************
// directed tests
// ********************************************************************

task automatic reset_check();
	int err_start;
	err_start = errors;
	repeat (RST_CYCLES - 1) begin
		@(negedge clk);
		expect_idle("out_valid in reset");
		compare_word("result_hi in reset", 64'd0, result_hi);
		compare_word("result_lo in reset", 64'd0, result_lo);
	end
	@(posedge clk);
	arst_n <= 1'b1;
	repeat (PIPE_LATENCY) begin
		@(negedge clk);
		expect_idle("out_valid after reset");
	end
	send_request(make_request(64'd6, 64'hffff_ffff_ffff_fffb, 1'b0, 2'b11));
	stop_driving();
	wait_for_results();
	finish_test("reset", err_start);
endtask

task automatic signedness_sweep();
	int err_start;
	err_start = errors;
	for (int s = 0; s < 4; s++) begin
		for (int i = 0; i < N_CORNER; i++) begin
			for (int j = 0; j < N_CORNER; j++) begin
				send_request(make_request(corner_value(i), corner_value(j), 1'b0, 2'(s)));
			end
		end
	end
	stop_driving();
	wait_for_results();
	finish_test("signedness", err_start);
endtask

task automatic mulw_random();
	int err_start;
	err_start = errors;
	for (int s = 0; s < 4; s++) begin
		repeat (MULW_PER_SIGN) begin
			send_request(make_request(random_word(), random_word(), 1'b1, 2'(s)));
		end
	end
	stop_driving();
	wait_for_results();
	finish_test("mulw", err_start);
endtask

task automatic back_to_back_burst();
	int err_start;
	int base;
	err_start = errors;
	base      = results;
	repeat (BURST_LEN) begin
		send_request(make_request(random_word(), random_word(),
			1'($urandom_range(0, 1)), 2'($urandom_range(0, 3))));
	end
	stop_driving();
	wait_for_results();
	compare_count("burst result count", BURST_LEN, results - base);
	finish_test("throughput", err_start);
endtask

task automatic flush_in_flight();
	int err_start;
	int base;
	int drop_base;
	err_start = errors;
	base      = results;
	drop_base = dropped;
	repeat (3) begin
		send_request(make_request(random_word(), random_word(), 1'b0, 2'b11));
	end
	// fourth request rides with the flush and is dropped.
	send_flush(make_request(random_word(), random_word(), 1'b0, 2'b00));
	stop_driving();
	send_request(make_request(64'h1234_5678_9abc_def0, 64'hfedc_ba98_7654_3210, 1'b0, 2'b01));
	stop_driving();
	wait_for_results();
	// the oldest is on the output at the flush edge.
	compare_count("requests killed by flush", 2, dropped - drop_base);
	compare_count("results around flush", 2, results - base);
	finish_test("flush", err_start);
endtask

`endif

//--- sim/tb_mul.sv
`timescale 1ns/1ps

module tb_mul;

	localparam int CLK_PERIOD    = 40;
	localparam int RST_CYCLES    = 5;
	localparam int PIPE_LATENCY  = 3;
	localparam int DRAIN_LIMIT   = 16;
	localparam int N_CORNER      = 5;
	localparam int MULW_PER_SIGN = 6;
	localparam int BURST_LEN     = 200;
	localparam int FLUSH_REQ     = 5;
	localparam int NUM_REQ       = 1 + 4 * N_CORNER * N_CORNER + 4 * MULW_PER_SIGN
		+ BURST_LEN + FLUSH_REQ;
	localparam logic [31:0] SEED = 32'hd053_a1a1;

	logic                     clk;
	logic                     arst_n;
	logic                     mul_valid;
	logic                     flush;
	mul_pkg::mul_req_t        req;
	logic [mul_pkg::XLEN-1:0] result_hi;
	logic [mul_pkg::XLEN-1:0] result_lo;
	logic                     out_valid;

	// scoreboard with one entry per accepted request.
	logic [mul_pkg::XLEN-1:0]   exp_hi [$];
	logic [mul_pkg::XLEN-1:0]   exp_lo [$];
	int                         exp_cycle [$];
	logic [2*mul_pkg::XLEN-1:0] expected_prod;

	int cycle   = 0;
	int errors  = 0;
	int checks  = 0;
	int results = 0;
	int dropped = 0;

	mul_top u_mul_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.mul_valid (mul_valid),
		.flush     (flush),
		.req       (req),
		.result_hi (result_hi),
		.result_lo (result_lo),
		.out_valid (out_valid)
	);

	`include "tb_mul_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ********************************************************************
	// checkers
	// ********************************************************************

	task automatic compare_word(
		input string                    name,
		input logic [mul_pkg::XLEN-1:0] expected,
		input logic [mul_pkg::XLEN-1:0] actual
	);
		checks++;
		assert (actual === expected) else begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_latency(input int accepted);
		checks++;
		assert (cycle - accepted == PIPE_LATENCY) else begin
			$display("Mismatch at %0t: latency expected %0d got %0d", $time, PIPE_LATENCY,
				cycle - accepted);
			errors++;
		end
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic expect_idle(input string name);
		checks++;
		assert (out_valid === 1'b0) else begin
			$display("Mismatch at %0t: %s expected 0 got %b", $time, name, out_valid);
			errors++;
		end
	endtask

	// reads here see the values from before this edge.
	always @(posedge clk) begin
		cycle++;
		if (arst_n) begin
			if (out_valid) begin
				results++;
				checks++;
				assert (exp_hi.size() != 0) else begin
					$display("unexpected result at %0t: out_valid with no request outstanding",
						$time);
					errors++;
				end
				if (exp_hi.size() != 0) begin
					compare_word("result_hi", exp_hi.pop_front(), result_hi);
					compare_word("result_lo", exp_lo.pop_front(), result_lo);
					compare_latency(exp_cycle.pop_front());
				end
			end
			// flush kills all that is still inside.
			if (flush) begin
				dropped += exp_hi.size();
				exp_hi.delete();
				exp_lo.delete();
				exp_cycle.delete();
			end else if (mul_valid) begin
				expected_prod = reference_product(req);
				exp_hi.push_back(expected_prod[2*mul_pkg::XLEN-1:mul_pkg::XLEN]);
				exp_lo.push_back(expected_prod[mul_pkg::XLEN-1:0]);
				exp_cycle.push_back(cycle);
			end
		end
	end

	initial begin
		#((NUM_REQ + 50) * CLK_PERIOD);
		$display("watchdog expired at %0t before the tests finished", $time);
		$display("TB FAILED");
		$finish;
	end

	// ********************************************************************
	// test sequence
	// ********************************************************************

	initial begin
		void'($urandom(SEED));
		arst_n    = 1'b0;
		mul_valid = 1'b0;
		flush     = 1'b0;
		req       = '0;

		reset_check();
		signedness_sweep();
		mulw_random();
		back_to_back_burst();
		flush_in_flight();

		$display("summary: %0d results, %0d checks, %0d flushed, %0d errors",
			results, checks, dropped, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- wallace/wallace_tree.sv
`timescale 1ns/1ps

module wallace_tree (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       flush,
	input  logic [mul_pkg::PROD_W-1:0] pp_rows [mul_pkg::PP_NUM],
	input  logic [mul_pkg::PROD_W-1:0] neg_row,
	input  logic                       in_valid,
	output mul_pkg::csa_pair_t         csa,
	output logic                       csa_valid
);

	// rows remaining after a given number of 3:2 layers.
	function automatic int rows_after(input int layers);
		int n;
		n = mul_pkg::TREE_ROWS;
		for (int i = 0; i < layers; i++) begin
			n = (n / 3) * 2 + n % 3;
		end
		return n;
	endfunction

	// layers until only sum and carry are left.
	function automatic int layer_count();
		int l;
		l = 0;
		while (rows_after(l) > 2) begin
			l++;
		end
		return l;
	endfunction

	localparam int LAYERS = layer_count();

	// level 0 is the input rows, level LAYERS the final pair.
	logic [mul_pkg::PROD_W-1:0] lvl [LAYERS+1][mul_pkg::TREE_ROWS];

	for (genvar k = 0; k < mul_pkg::PP_NUM; k++) begin : g_load
		assign lvl[0][k] = pp_rows[k];
	end
	assign lvl[0][mul_pkg::PP_NUM] = neg_row;

	// ********************************************************************
	// 3:2 compressor layers
	// ********************************************************************

	for (genvar l = 0; l < LAYERS; l++) begin : g_layer
		localparam int N_IN  = rows_after(l);
		localparam int N_GRP = N_IN / 3;
		localparam int N_OUT = rows_after(l + 1);

		for (genvar g = 0; g < N_GRP; g++) begin : g_csa
			logic [mul_pkg::PROD_W-1:0] x;
			logic [mul_pkg::PROD_W-1:0] y;
			logic [mul_pkg::PROD_W-1:0] z;

			assign x = lvl[l][3*g];
			assign y = lvl[l][3*g+1];
			assign z = lvl[l][3*g+2];

			assign lvl[l+1][2*g]   = x ^ y ^ z;
			// carry moves one weight up, the top bit falls off.
			assign lvl[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
		end

		// leftover rows skip this layer.
		for (genvar r = 0; r < N_IN - 3 * N_GRP; r++) begin : g_pass
			assign lvl[l+1][2*N_GRP+r] = lvl[l][3*N_GRP+r];
		end

		for (genvar u = N_OUT; u < mul_pkg::TREE_ROWS; u++) begin : g_idle
			assign lvl[l+1][u] = '0;
		end
	end

	// ********************************************************************
	// stage 2 registers
	// ********************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			csa_valid <= 1'b0;
		end else begin
			csa_valid <= in_valid & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			csa.sum   <= lvl[LAYERS][0];
			csa.carry <= lvl[LAYERS][1];
		end
	end

endmodule
